//--- dv/tb_clk_rst.sv
`timescale 1ns/1ps

module tb_clk_rst #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- dv/tb_replay_top.sv
`timescale 1ns/1ps

module tb_replay_top;

  localparam int DATA_WIDTH      = 32;
  localparam int RETRY_SLOTS     = 4;
  localparam int MAX_TLP_WORDS   = 8;
  localparam int TIMER_LIMIT     = replay_buf_pkg::RETRY_TIMER_LIMIT;
  localparam int MAX_REPLAYS_INT = int'(replay_buf_pkg::MAX_REPLAYS);
  localparam int MODEL_DEPTH     = 32;
  localparam int NUM_TESTS       = 6;
  localparam int TIMEOUT_CYCLES  =
    NUM_TESTS * 4 * (TIMER_LIMIT + 2 * MAX_TLP_WORDS + 10);

  // what an entry does with its TLP
  localparam logic [2:0] M_ACK    = 3'd0;
  localparam logic [2:0] M_REPLAY = 3'd1;
  localparam logic [2:0] M_NAK    = 3'd2;
  localparam logic [2:0] M_FILL   = 3'd3;
  localparam logic [2:0] M_ERR    = 3'd4;

  typedef struct packed {
    logic [3:0]            words;
    logic [DATA_WIDTH-1:0] base;
    logic [2:0]            mode;
    logic [7:0]            ack_delay;
    logic                  rand_ready;
  } entry_t;

  logic                   clk;
  logic                   rst;
  logic [DATA_WIDTH-1:0]  tlp_data;
  logic                   tlp_valid;
  logic                   tlp_last;
  logic                   tlp_ready;
  logic                   ack_nack;
  logic                   ack_nack_vld;
  dll_link_pkg::seq_num_t ack_seq_num;
  logic [DATA_WIDTH-1:0]  m_axis_tdata;
  logic                   m_axis_tvalid;
  logic                   m_axis_tlast;
  logic                   m_axis_tready;
  logic                   retry_available;
  logic                   retry_err;

  entry_t                 tests [NUM_TESTS];
  logic [DATA_WIDTH-1:0]  model_data [MODEL_DEPTH][MAX_TLP_WORDS];
  int                     model_len [MODEL_DEPTH];
  logic [DATA_WIDTH:0]    obs_q [$];
  dll_link_pkg::seq_num_t next_seq = '0;
  integer                 seed = 32'hdb9bb154;
  logic                   rand_ready = 1'b0;
  logic                   err_expected = 1'b0;
  int                     valid_cycles = 0;
  int                     unavail_cycles = 0;
  int                     last_count = 0;
  int                     word_errs = 0;
  int                     flag_errs = 0;
  int                     seq_errs = 0;

  tb_clk_rst #(
    .PERIOD_NS (20),
    .RST_CYCLES(4)
  ) u_clk_rst (
    .clk_o(clk),
    .rst_o(rst)
  );

  replay_top #(
    .DATA_WIDTH   (DATA_WIDTH),
    .RETRY_SLOTS  (RETRY_SLOTS),
    .MAX_TLP_WORDS(MAX_TLP_WORDS)
  ) u_dut (
    .clk_i            (clk),
    .rst_i            (rst),
    .tlp_data_i       (tlp_data),
    .tlp_valid_i      (tlp_valid),
    .tlp_last_i       (tlp_last),
    .tlp_ready_o      (tlp_ready),
    .ack_nack_i       (ack_nack),
    .ack_nack_vld_i   (ack_nack_vld),
    .ack_seq_num_i    (ack_seq_num),
    .m_axis_tdata_o   (m_axis_tdata),
    .m_axis_tvalid_o  (m_axis_tvalid),
    .m_axis_tlast_o   (m_axis_tlast),
    .m_axis_tready_i  (m_axis_tready),
    .retry_available_o(retry_available),
    .retry_err_o      (retry_err)
  );

  // ready is either held high or gapped at random
  initial begin
    m_axis_tready = 1'b1;
    forever begin
      @(posedge clk);
      if (rand_ready) begin
        m_axis_tready <= (($random(seed) & 3) != 0);
      end else begin
        m_axis_tready <= 1'b1;
      end
    end
  end

  // output sampled mid-cycle, a word moves on the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      if (m_axis_tvalid && m_axis_tready) begin
        obs_q.push_back({m_axis_tlast, m_axis_tdata});
        if (m_axis_tlast) begin
          last_count++;
        end
      end
      if (m_axis_tvalid) begin
        valid_cycles++;
      end
      if (!retry_available) begin
        unavail_cycles++;
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [DATA_WIDTH-1:0] word_value(input logic [DATA_WIDTH-1:0] base,
                                                       input int k);
    return base + DATA_WIDTH'((k + 1) * 32'h0001_0003);
  endfunction

  task automatic check_word(input logic [DATA_WIDTH-1:0] got_data, input logic got_last,
                            input logic [DATA_WIDTH-1:0] exp_data, input logic exp_last,
                            input string what);
    if (got_data !== exp_data || got_last !== exp_last) begin
      word_errs++;
      $display("MISMATCH at %0t: %s data %h last %b, expected %h last %b",
               $time, what, got_data, got_last, exp_data, exp_last);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_seq(input dll_link_pkg::seq_num_t got,
                           input dll_link_pkg::seq_num_t exp, input string what);
    if (got !== exp) begin
      seq_errs++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic send_tlp(input int n, input logic [DATA_WIDTH-1:0] base,
                          output dll_link_pkg::seq_num_t seq);
    int idx;
    @(negedge clk);
    while (!tlp_ready) @(negedge clk);
    seq = next_seq;
    idx = int'(next_seq) % MODEL_DEPTH;
    model_len[idx] = n;
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      tlp_valid <= 1'b1;
      tlp_data  <= word_value(base, k);
      tlp_last  <= (k == n - 1);
      model_data[idx][k] = word_value(base, k);
    end
    @(posedge clk);
    tlp_valid <= 1'b0;
    tlp_last  <= 1'b0;
    // stored TLP announced the cycle after its last word
    @(negedge clk);
    check_flag(u_dut.tx_valid, 1'b1, "tx_valid after last word");
    check_seq(u_dut.tx_seq_num, seq, "announced sequence number");
    next_seq = next_seq + 1'b1;
  endtask

  task automatic send_ack(input dll_link_pkg::seq_num_t seq, input logic ack);
    @(posedge clk);
    ack_nack_vld <= 1'b1;
    ack_nack     <= ack;
    ack_seq_num  <= seq;
    @(posedge clk);
    ack_nack_vld <= 1'b0;
  endtask

  task automatic expect_replay(input dll_link_pkg::seq_num_t seq, input string what);
    int idx;
    int len;
    logic [DATA_WIDTH:0] item;
    idx = int'(seq) % MODEL_DEPTH;
    len = model_len[idx];
    for (int k = 0; k < len; k++) begin
      while (obs_q.size() == 0) @(posedge clk);
      item = obs_q.pop_front();
      check_word(item[DATA_WIDTH-1:0], item[DATA_WIDTH], model_data[idx][k], k == len - 1,
                 $sformatf("%s word %0d of seq %0d", what, k, seq));
    end
  endtask

  task automatic run_entry(input entry_t e);
    dll_link_pkg::seq_num_t seq;
    dll_link_pkg::seq_num_t fill_seq [RETRY_SLOTS];
    int start_cnt;
    int start_gap;
    @(negedge clk);
    rand_ready = e.rand_ready;
    case (e.mode)
      M_ACK: begin
        send_tlp(int'(e.words), e.base, seq);
        repeat (int'(e.ack_delay)) @(posedge clk);
        send_ack(seq, dll_link_pkg::ACK);
        start_cnt = valid_cycles;
        start_gap = unavail_cycles;
        repeat (2 * TIMER_LIMIT) @(posedge clk);
        check_flag(valid_cycles == start_cnt, 1'b1, "quiet output after ACK");
        check_flag(unavail_cycles == start_gap, 1'b1, "available held after ACK");
      end
      M_REPLAY, M_NAK: begin
        send_tlp(int'(e.words), e.base, seq);
        if (e.mode == M_NAK) begin
          repeat (int'(e.ack_delay)) @(posedge clk);
          send_ack(seq, dll_link_pkg::NAK);
        end
        expect_replay(seq, "replay");
        send_ack(seq, dll_link_pkg::ACK);
      end
      M_FILL: begin
        for (int i = 0; i < RETRY_SLOTS; i++) begin
          send_tlp(int'(e.words), e.base + DATA_WIDTH'(i << 16), fill_seq[i]);
        end
        @(negedge clk);
        check_flag(retry_available, 1'b0, "retry_available with all slots full");
        check_flag(tlp_ready, 1'b0, "tlp_ready with all slots full");
        send_ack(fill_seq[1], dll_link_pkg::ACK);
        @(negedge clk);
        while (!retry_available) @(negedge clk);
        check_flag(tlp_ready, 1'b1, "tlp_ready after freeing a slot");
        send_tlp(int'(e.words), e.base + DATA_WIDTH'(32'h0800_0000), seq);
        send_ack(fill_seq[0], dll_link_pkg::ACK);
        send_ack(fill_seq[2], dll_link_pkg::ACK);
        send_ack(fill_seq[3], dll_link_pkg::ACK);
        expect_replay(seq, "reused slot");
        send_ack(seq, dll_link_pkg::ACK);
      end
      default: begin
        send_tlp(int'(e.words), e.base, seq);
        start_cnt = last_count;
        for (int r = 0; r < MAX_REPLAYS_INT; r++) begin
          expect_replay(seq, $sformatf("replay %0d", r));
        end
        @(negedge clk);
        while (!retry_err) @(negedge clk);
        err_expected = 1'b1;
        check_flag(last_count - start_cnt == MAX_REPLAYS_INT, 1'b1, "replays before error");
        check_flag(obs_q.size() == 0, 1'b1, "no replay past the limit");
        send_ack(seq, dll_link_pkg::ACK);
      end
    endcase
    repeat (4) @(posedge clk);
    @(negedge clk);
    rand_ready = 1'b0;
    check_flag(retry_available, 1'b1, "retry_available at end of entry");
    check_flag(retry_err, err_expected, "retry_err");
    check_flag(obs_q.size() == 0, 1'b1, "no stray replay words");
  endtask

  task automatic load_table;
    tests[0] = '{4'd3, 32'h1000_0000, M_ACK, 8'd40, 1'b0};
    tests[1] = '{4'd5, 32'h2000_0000, M_REPLAY, 8'd0, 1'b0};
    tests[2] = '{4'd8, 32'h3000_0000, M_REPLAY, 8'd0, 1'b1};
    tests[3] = '{4'd1, 32'h4000_0000, M_NAK, 8'd20, 1'b0};
    tests[4] = '{4'd4, 32'h5000_0000, M_FILL, 8'd0, 1'b0};
    // error is sticky, so this one runs last
    tests[5] = '{4'd6, 32'h6000_0000, M_ERR, 8'd0, 1'b1};
  endtask

  initial begin
    int total;
    tlp_data     = '0;
    tlp_valid    = 1'b0;
    tlp_last     = 1'b0;
    ack_nack     = 1'b0;
    ack_nack_vld = 1'b0;
    ack_seq_num  = '0;
    load_table();
    @(negedge clk);
    while (rst) @(negedge clk);
    check_flag(retry_available, 1'b1, "retry_available after reset");
    check_flag(tlp_ready, 1'b1, "tlp_ready after reset");
    check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
    check_flag(retry_err, 1'b0, "retry_err after reset");
    check_flag(u_dut.wr_en, 1'b0, "ram write enable after reset");
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_entry(tests[t]);
    end
    total = word_errs + flag_errs + seq_errs;
    $display("error counts: word %0d, flag %0d, seq %0d", word_errs, flag_errs, seq_errs);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- hdl/dll_link_pkg.sv
package dll_link_pkg;

  // sequence number carried by every TLP and by ACK/NAK DLLPs
  localparam int SEQ_W = 12;

  typedef logic [SEQ_W-1:0] seq_num_t;

  // ack_nack_i encoding
  localparam logic ACK = 1'b1;
  localparam logic NAK = 1'b0;

endpackage

//--- hdl/replay_buf_pkg.sv
package replay_buf_pkg;

  // timer value at which an unacknowledged slot is replayed
  localparam int RETRY_TIMER_LIMIT = 'hA0;

  // replays before the next timeout turns into an error
  localparam logic [1:0] MAX_REPLAYS = 2'd3;

  // per-slot retry state
  typedef enum logic [2:0] {
    ST_RETRY_IDLE,
    ST_CNT_RETRY,
    ST_REPLAY,
    ST_WAIT_REPLAY,
    ST_RETRY_ERR
  } retry_st_e;

  // count word followed by the payload words
  function automatic int slot_stride(input int max_tlp_words);
    return max_tlp_words + 1;
  endfunction

  // first ram address of a slot, which holds the word count
  function automatic int slot_base(input int slot, input int max_tlp_words);
    return slot * slot_stride(max_tlp_words);
  endfunction

endpackage

//--- hdl/replay_ram.sv
`timescale 1ns/1ps

module replay_ram #(
  parameter int DATA_WIDTH     = 32,
  parameter int RAM_ADDR_WIDTH = 6
) (
  input  logic                      clk_i,
  input  logic                      wr_en_i,
  input  logic [RAM_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [DATA_WIDTH-1:0]     wr_data_i,
  input  logic [RAM_ADDR_WIDTH-1:0] rd_addr_i,
  output logic [DATA_WIDTH-1:0]     rd_data_o
);

  logic [DATA_WIDTH-1:0] mem_r [2**RAM_ADDR_WIDTH];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_r[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem_r[rd_addr_i];
  end

endmodule

//--- hdl/replay_top.sv
`timescale 1ns/1ps

module replay_top #(
  parameter int DATA_WIDTH    = 32,
  parameter int RETRY_SLOTS   = 4,
  parameter int MAX_TLP_WORDS = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [DATA_WIDTH-1:0]  tlp_data_i,
  input  logic                   tlp_valid_i,
  input  logic                   tlp_last_i,
  output logic                   tlp_ready_o,
  input  logic                   ack_nack_i,
  input  logic                   ack_nack_vld_i,
  input  dll_link_pkg::seq_num_t ack_seq_num_i,
  output logic [DATA_WIDTH-1:0]  m_axis_tdata_o,
  output logic                   m_axis_tvalid_o,
  output logic                   m_axis_tlast_o,
  input  logic                   m_axis_tready_i,
  output logic                   retry_available_o,
  output logic                   retry_err_o
);

  // all slots back to back, each a count word plus payload
  localparam int RamDepth       = replay_buf_pkg::slot_base(RETRY_SLOTS, MAX_TLP_WORDS);
  localparam int RAM_ADDR_WIDTH = $clog2(RamDepth);
  localparam int IdxW           = $clog2(RETRY_SLOTS);

  logic                      wr_en;
  logic [RAM_ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0]     wr_data;
  logic [RAM_ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0]     rd_data;
  logic                      tx_valid;
  dll_link_pkg::seq_num_t    tx_seq_num;
  logic [IdxW-1:0]           retry_index;

  tlp_replay_writer #(
    .DATA_WIDTH    (DATA_WIDTH),
    .RETRY_SLOTS   (RETRY_SLOTS),
    .MAX_TLP_WORDS (MAX_TLP_WORDS),
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) u_writer (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .tlp_data_i       (tlp_data_i),
    .tlp_valid_i      (tlp_valid_i),
    .tlp_last_i       (tlp_last_i),
    .tlp_ready_o      (tlp_ready_o),
    .retry_available_i(retry_available_o),
    .retry_index_i    (retry_index),
    .ram_wr_en_o      (wr_en),
    .ram_wr_addr_o    (wr_addr),
    .ram_wr_data_o    (wr_data),
    .tx_valid_o       (tx_valid),
    .tx_seq_num_o     (tx_seq_num)
  );

  replay_ram #(
    .DATA_WIDTH    (DATA_WIDTH),
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) u_ram (
    .clk_i    (clk_i),
    .wr_en_i  (wr_en),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data)
  );

  retry_management #(
    .DATA_WIDTH    (DATA_WIDTH),
    .RETRY_SLOTS   (RETRY_SLOTS),
    .MAX_TLP_WORDS (MAX_TLP_WORDS),
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) u_retry (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .tx_seq_num_i     (tx_seq_num),
    .tx_valid_i       (tx_valid),
    .retry_available_o(retry_available_o),
    .retry_index_o    (retry_index),
    .retry_err_o      (retry_err_o),
    .ack_nack_i       (ack_nack_i),
    .ack_nack_vld_i   (ack_nack_vld_i),
    .ack_seq_num_i    (ack_seq_num_i),
    .bram_addr_o      (rd_addr),
    .bram_data_in_i   (rd_data),
    .m_axis_tdata_o   (m_axis_tdata_o),
    .m_axis_tvalid_o  (m_axis_tvalid_o),
    .m_axis_tlast_o   (m_axis_tlast_o),
    .m_axis_tready_i  (m_axis_tready_i)
  );

endmodule

//--- hdl/retry_management.sv
`timescale 1ns/1ps

module retry_management #(
  parameter int DATA_WIDTH     = 32,
  parameter int RETRY_SLOTS    = 4,
  parameter int MAX_TLP_WORDS  = 8,
  parameter int RAM_ADDR_WIDTH = 6
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  dll_link_pkg::seq_num_t         tx_seq_num_i,
  input  logic                           tx_valid_i,
  output logic                           retry_available_o,
  output logic [$clog2(RETRY_SLOTS)-1:0] retry_index_o,
  output logic                           retry_err_o,
  input  logic                           ack_nack_i,
  input  logic                           ack_nack_vld_i,
  input  dll_link_pkg::seq_num_t         ack_seq_num_i,
  output logic [RAM_ADDR_WIDTH-1:0]      bram_addr_o,
  input  logic [DATA_WIDTH-1:0]          bram_data_in_i,
  output logic [DATA_WIDTH-1:0]          m_axis_tdata_o,
  output logic                           m_axis_tvalid_o,
  output logic                           m_axis_tlast_o,
  input  logic                           m_axis_tready_i
);

  localparam int IdxW   = $clog2(RETRY_SLOTS);
  localparam int CntW   = $clog2(MAX_TLP_WORDS + 1);
  localparam int TimerW = $clog2(replay_buf_pkg::RETRY_TIMER_LIMIT + 1);

  typedef enum logic [2:0] {
    RP_IDLE,
    RP_COUNT,
    RP_ADDR,
    RP_LOAD,
    RP_STREAM
  } replay_st_e;

  logic [RETRY_SLOTS-1:0] occupied_r;
  dll_link_pkg::seq_num_t seq_mem_r [RETRY_SLOTS];
  logic                   free_req_r;
  dll_link_pkg::seq_num_t free_seq_r;
  logic [IdxW-1:0]        next_idx_r;
  logic [IdxW-1:0]        lowest_free;
  logic [IdxW-1:0]        lowest_free_other;
  logic                   any_free;
  logic                   any_free_other;
  logic                   err_r;

  logic [RETRY_SLOTS-1:0] replay_req;
  logic [RETRY_SLOTS-1:0] replay_grant;
  logic [RETRY_SLOTS-1:0] slot_err;
  logic                   any_req;
  logic [IdxW-1:0]        grant_idx;
  logic                   replay_done;

  replay_st_e             rp_state_r;
  logic [IdxW-1:0]        act_idx_r;
  logic [CntW-1:0]        word_cnt_r;
  logic [CntW-1:0]        sent_r;
  logic [CntW-1:0]        sent_c;
  logic [RAM_ADDR_WIDTH-1:0] slot_addr;
  logic [DATA_WIDTH-1:0]  tdata_r;
  logic                   tvalid_r;
  logic                   tlast_r;

  // lowest free slot, and lowest free one besides the slot being stored
  always_comb begin
    any_free          = 1'b0;
    lowest_free       = '0;
    any_free_other    = 1'b0;
    lowest_free_other = '0;
    for (int i = RETRY_SLOTS - 1; i >= 0; i--) begin
      if (!occupied_r[i]) begin
        any_free    = 1'b1;
        lowest_free = IdxW'(i);
        if (IdxW'(i) != next_idx_r) begin
          any_free_other    = 1'b1;
          lowest_free_other = IdxW'(i);
        end
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      occupied_r <= '0;
      free_req_r <= 1'b0;
      next_idx_r <= '0;
      err_r      <= 1'b0;
    end else begin
      free_req_r <= ack_nack_vld_i && (ack_nack_i == dll_link_pkg::ACK);
      // exact sequence match only
      for (int i = 0; i < RETRY_SLOTS; i++) begin
        if (free_req_r && occupied_r[i] && (seq_mem_r[i] == free_seq_r)) begin
          occupied_r[i] <= 1'b0;
        end
      end
      if (tx_valid_i) begin
        occupied_r[next_idx_r] <= 1'b1;
        if (any_free_other) begin
          next_idx_r <= lowest_free_other;
        end
      end else if (occupied_r[next_idx_r]) begin
        next_idx_r <= lowest_free;
      end
      if (|slot_err) begin
        err_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_valid_i) begin
      seq_mem_r[next_idx_r] <= tx_seq_num_i;
    end
    if (ack_nack_vld_i) begin
      free_seq_r <= ack_seq_num_i;
    end
  end

  for (genvar i = 0; i < RETRY_SLOTS; i++) begin : gen_slot
    replay_buf_pkg::retry_st_e state_r;
    replay_buf_pkg::retry_st_e state_c;
    logic [TimerW-1:0] timer_r;
    logic [TimerW-1:0] timer_c;
    logic [1:0]        replays_r;
    logic [1:0]        replays_c;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        state_r   <= replay_buf_pkg::ST_RETRY_IDLE;
        timer_r   <= '0;
        replays_r <= '0;
      end else begin
        state_r   <= state_c;
        timer_r   <= timer_c;
        replays_r <= replays_c;
      end
    end

    always_comb begin
      state_c   = state_r;
      timer_c   = timer_r;
      replays_c = replays_r;
      if (!occupied_r[i]) begin
        // acked, back to idle from any state
        state_c   = replay_buf_pkg::ST_RETRY_IDLE;
        timer_c   = '0;
        replays_c = '0;
      end else begin
        case (state_r)
          replay_buf_pkg::ST_RETRY_IDLE: begin
            state_c = replay_buf_pkg::ST_CNT_RETRY;
          end
          replay_buf_pkg::ST_CNT_RETRY: begin
            if (timer_r == TimerW'(replay_buf_pkg::RETRY_TIMER_LIMIT)) begin
              timer_c = '0;
              if (replays_r == replay_buf_pkg::MAX_REPLAYS) begin
                state_c = replay_buf_pkg::ST_RETRY_ERR;
              end else begin
                replays_c = replays_r + 1'b1;
                state_c   = replay_buf_pkg::ST_REPLAY;
              end
            end else begin
              timer_c = timer_r + 1'b1;
            end
          end
          replay_buf_pkg::ST_REPLAY: begin
            if (replay_grant[i]) begin
              state_c = replay_buf_pkg::ST_WAIT_REPLAY;
            end
          end
          replay_buf_pkg::ST_WAIT_REPLAY: begin
            if (replay_done && (act_idx_r == IdxW'(i))) begin
              timer_c = '0;
              state_c = replay_buf_pkg::ST_CNT_RETRY;
            end
          end
          default: begin
          end
        endcase
      end
    end

    assign replay_req[i] = (state_r == replay_buf_pkg::ST_REPLAY);
    assign slot_err[i]   = (state_r == replay_buf_pkg::ST_RETRY_ERR);
  end : gen_slot

  // lowest requesting slot wins
  always_comb begin
    any_req      = |replay_req;
    grant_idx    = '0;
    replay_grant = '0;
    for (int i = RETRY_SLOTS - 1; i >= 0; i--) begin
      if (replay_req[i]) begin
        grant_idx = IdxW'(i);
      end
    end
    if ((rp_state_r == RP_IDLE) && any_req) begin
      replay_grant[grant_idx] = 1'b1;
    end
  end

  // words already loaded into the output register
  always_comb begin
    sent_c = sent_r;
    case (rp_state_r)
      RP_ADDR:   sent_c = '0;
      RP_LOAD:   sent_c = CntW'(1);
      RP_STREAM: begin
        if (tvalid_r && m_axis_tready_i && !tlast_r) begin
          sent_c = sent_r + 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  // address held while stalled so rd_data keeps the next word
  assign slot_addr   = RAM_ADDR_WIDTH'(replay_buf_pkg::slot_base(int'(act_idx_r), MAX_TLP_WORDS));
  assign bram_addr_o = (rp_state_r == RP_COUNT) ? slot_addr
                                                : slot_addr + RAM_ADDR_WIDTH'(sent_c) + 1'b1;

  assign replay_done = (rp_state_r == RP_STREAM) && tvalid_r && m_axis_tready_i && tlast_r;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rp_state_r <= RP_IDLE;
      sent_r     <= '0;
      tvalid_r   <= 1'b0;
      tlast_r    <= 1'b0;
    end else begin
      sent_r <= sent_c;
      case (rp_state_r)
        RP_IDLE: begin
          if (any_req) begin
            rp_state_r <= RP_COUNT;
          end
        end
        RP_COUNT: rp_state_r <= RP_ADDR;
        RP_ADDR:  rp_state_r <= RP_LOAD;
        RP_LOAD: begin
          tvalid_r   <= 1'b1;
          tlast_r    <= (word_cnt_r == CntW'(1));
          rp_state_r <= RP_STREAM;
        end
        RP_STREAM: begin
          if (tvalid_r && m_axis_tready_i) begin
            if (tlast_r) begin
              tvalid_r   <= 1'b0;
              tlast_r    <= 1'b0;
              rp_state_r <= RP_IDLE;
            end else begin
              tlast_r <= (sent_r + 1'b1 == word_cnt_r);
            end
          end
        end
        default: rp_state_r <= RP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rp_state_r == RP_IDLE) begin
      act_idx_r <= grant_idx;
    end
    if (rp_state_r == RP_ADDR) begin
      word_cnt_r <= bram_data_in_i[CntW-1:0];
    end
    if ((rp_state_r == RP_LOAD) ||
        ((rp_state_r == RP_STREAM) && tvalid_r && m_axis_tready_i && !tlast_r)) begin
      tdata_r <= bram_data_in_i;
    end
  end

  assign retry_available_o = any_free;
  assign retry_index_o     = occupied_r[next_idx_r] ? lowest_free : next_idx_r;
  assign retry_err_o       = err_r;

  assign m_axis_tdata_o  = tdata_r;
  assign m_axis_tvalid_o = tvalid_r;
  assign m_axis_tlast_o  = tlast_r;

endmodule

//--- hdl/tlp_replay_writer.sv
`timescale 1ns/1ps

module tlp_replay_writer #(
  parameter int DATA_WIDTH     = 32,
  parameter int RETRY_SLOTS    = 4,
  parameter int MAX_TLP_WORDS  = 8,
  parameter int RAM_ADDR_WIDTH = 6
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [DATA_WIDTH-1:0]          tlp_data_i,
  input  logic                           tlp_valid_i,
  input  logic                           tlp_last_i,
  output logic                           tlp_ready_o,
  input  logic                           retry_available_i,
  input  logic [$clog2(RETRY_SLOTS)-1:0] retry_index_i,
  output logic                           ram_wr_en_o,
  output logic [RAM_ADDR_WIDTH-1:0]      ram_wr_addr_o,
  output logic [DATA_WIDTH-1:0]          ram_wr_data_o,
  output logic                           tx_valid_o,
  output dll_link_pkg::seq_num_t         tx_seq_num_o
);

  localparam int IdxW = $clog2(RETRY_SLOTS);
  localparam int CntW = $clog2(MAX_TLP_WORDS + 1);

  logic                   busy_r;
  logic                   fin_r;
  logic [IdxW-1:0]        slot_r;
  logic [IdxW-1:0]        cur_slot;
  logic [CntW-1:0]        cnt_r;
  logic [CntW-1:0]        cur_cnt;
  dll_link_pkg::seq_num_t seq_r;

  // slot index taken from the retry manager at the first word only
  assign cur_slot = busy_r ? slot_r : retry_index_i;
  assign cur_cnt  = busy_r ? cnt_r : '0;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_r <= 1'b0;
      fin_r  <= 1'b0;
      seq_r  <= '0;
    end else begin
      fin_r <= tlp_valid_i && tlp_last_i;
      if (tlp_valid_i) begin
        busy_r <= !tlp_last_i;
      end
      // wraps at 12 bits
      if (fin_r) begin
        seq_r <= seq_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tlp_valid_i) begin
      slot_r <= cur_slot;
      cnt_r  <= cur_cnt + 1'b1;
    end
  end

  // payload words at base+1+k, count word at base once the TLP is done
  always_comb begin
    ram_wr_en_o = tlp_valid_i || fin_r;
    if (fin_r) begin
      ram_wr_addr_o = RAM_ADDR_WIDTH'(replay_buf_pkg::slot_base(int'(slot_r), MAX_TLP_WORDS));
      ram_wr_data_o = DATA_WIDTH'(cnt_r);
    end else begin
      ram_wr_addr_o = RAM_ADDR_WIDTH'(replay_buf_pkg::slot_base(int'(cur_slot), MAX_TLP_WORDS)
                                      + 1 + int'(cur_cnt));
      ram_wr_data_o = tlp_data_i;
    end
  end

  assign tlp_ready_o  = retry_available_i && !fin_r;
  assign tx_valid_o   = fin_r;
  assign tx_seq_num_o = seq_r;

endmodule

//--- run.sh
#!/bin/sh
# build and run the replay buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_replay_top -f verilog.f \
  -Mdir obj_dir -o tb_replay_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_replay_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
  exit 0
fi
exit 1

//--- verilog.f
hdl/dll_link_pkg.sv
hdl/replay_buf_pkg.sv
hdl/replay_ram.sv
hdl/tlp_replay_writer.sv
hdl/retry_management.sv
hdl/replay_top.sv
dv/tb_clk_rst.sv
dv/tb_replay_top.sv
